//--- clause_cell.sv
`timescale 1ns/10ps

module clause_cell import sat_bcp_pkg::*; #(
    parameter int NUM_VARS    = NUM_VARS_D,
    parameter int WIDTH_LVL   = WIDTH_LVL_D,
    parameter int WIDTH_C_LEN = WIDTH_C_LEN_D
) (
    input  logic                                clk,
    input  logic                                rst,
    input  var_t [NUM_VARS-1:0]                 var_i,
    output var_t [NUM_VARS-1:0]                 var_o,
    input  logic [NUM_VARS-1:0][WIDTH_LVL-1:0] lvl_i,
    input  logic [WIDTH_LVL-1:0]                cur_lvl_i,
    input  logic [WIDTH_LVL-1:0]                chain_lvl_i,
    output logic [WIDTH_LVL-1:0]                chain_lvl_o,
    input  logic                                wr_i,
    input  logic                                rd_i,
    input  lit_e [NUM_VARS-1:0]                 clause_i,
    output lit_e [NUM_VARS-1:0]                 clause_o,
    input  logic [WIDTH_C_LEN-1:0]              clause_len_i,
    output logic [WIDTH_C_LEN-1:0]              clause_len_o,
    input  logic                                apply_impl_i,
    input  logic                                apply_bkt_i,
    input  logic [WIDTH_LVL-1:0]                bkt_target_i,
    output logic                                cclause_o,
    output logic                                sat_o
);

    lit_e [NUM_VARS-1:0]    lits;
    logic [1:0]             freelitcnt;
    logic                   clausesat;
    logic                   nonempty;
    logic                   imp_drv;
    logic [WIDTH_LVL-1:0]   max_lvl;
    logic [WIDTH_C_LEN-1:0] len_r;
    logic                   is_reason;
    logic [WIDTH_LVL-1:0]   reason_lvl;

    lit_array #(
        .NUM_VARS  (NUM_VARS),
        .WIDTH_LVL (WIDTH_LVL)
    ) lit_array_i (
        .clk          (clk),
        .rst          (rst),
        .wr_i         (wr_i),
        .lit_i        (clause_i),
        .lit_o        (lits),
        .var_i        (var_i),
        .var_o        (var_o),
        .lvl_i        (lvl_i),
        .imp_drv_i    (imp_drv),
        .freelitcnt_o (freelitcnt),
        .clausesat_o  (clausesat),
        .max_lvl_o    (max_lvl)
    );

    always_comb begin
        nonempty = 1'b0;
        for (int i = 0; i < NUM_VARS; i++) begin
            nonempty = nonempty | (lits[i] != L_NONE);
            clause_o[i] = rd_i ? lits[i] : L_NONE;
        end
    end

    terminal_cell #(
        .WIDTH_LVL (WIDTH_LVL)
    ) terminal_cell_i (
        .clausesat_i  (clausesat),
        .freelitcnt_i (freelitcnt),
        .nonempty_i   (nonempty),
        .max_lvl_i    (max_lvl),
        .chain_lvl_i  (chain_lvl_i),
        .imp_drv_o    (imp_drv),
        .cclause_o    (cclause_o),
        .chain_lvl_o  (chain_lvl_o)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            len_r     <= '0;
            is_reason <= 1'b0;
        end else begin
            if (wr_i) begin
                len_r <= clause_len_i;
            end
            if (wr_i) begin
                is_reason <= 1'b0; // new clause implied nothing yet
            end else if (apply_bkt_i && bkt_target_i < reason_lvl) begin
                is_reason <= 1'b0; // implied variable is freed
            end else if (apply_impl_i && imp_drv) begin
                is_reason <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (apply_impl_i && imp_drv) begin
            reason_lvl <= cur_lvl_i;
        end
    end

    assign clause_len_o = is_reason ? '0 : len_r;
    assign sat_o        = clausesat || !nonempty;

endmodule

//--- lit_array.sv
`timescale 1ns/10ps

module lit_array import sat_bcp_pkg::*; #(
    parameter int NUM_VARS  = NUM_VARS_D,
    parameter int WIDTH_LVL = WIDTH_LVL_D
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_i,
    input  lit_e [NUM_VARS-1:0]                 lit_i,
    output lit_e [NUM_VARS-1:0]                 lit_o,
    input  var_t [NUM_VARS-1:0]                 var_i,
    output var_t [NUM_VARS-1:0]                 var_o,
    input  logic [NUM_VARS-1:0][WIDTH_LVL-1:0] lvl_i,
    input  logic                                imp_drv_i,
    output logic [1:0]                          freelitcnt_o,
    output logic                                clausesat_o,
    output logic [WIDTH_LVL-1:0]                max_lvl_o
);

    lit_e [NUM_VARS-1:0]                 lit_r;
    logic [NUM_VARS-1:0]                 is_free;
    logic [NUM_VARS-1:0]                 is_sat;
    logic [NUM_VARS-1:0]                 is_false;
    logic [NUM_VARS-1:0][WIDTH_LVL-1:0] false_lvl;

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_VARS; i++) begin
                lit_r[i] <= L_NONE; // empty clause
            end
        end else if (wr_i) begin
            lit_r <= lit_i;
        end
    end

    assign lit_o = lit_r;

    for (genvar i = 0; i < NUM_VARS; i++) begin : g_lit
        lit_cell #(
            .WIDTH_LVL (WIDTH_LVL)
        ) lit_cell_i (
            .var_i       (var_i[i]),
            .lvl_i       (lvl_i[i]),
            .lit_i       (lit_r[i]),
            .imp_drv_i   (imp_drv_i),
            .var_o       (var_o[i]),
            .is_free_o   (is_free[i]),
            .is_sat_o    (is_sat[i]),
            .is_false_o  (is_false[i]),
            .false_lvl_o (false_lvl[i])
        );
    end

    // only zero, one or more than one free literal matter to the terminal
    always_comb begin
        freelitcnt_o = 2'd0;
        clausesat_o  = 1'b0;
        max_lvl_o    = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (is_free[i] && freelitcnt_o != 2'd2) begin
                freelitcnt_o = freelitcnt_o + 2'd1;
            end
            clausesat_o = clausesat_o | is_sat[i];
            if (is_false[i] && false_lvl[i] > max_lvl_o) begin
                max_lvl_o = false_lvl[i];
            end
        end
    end

endmodule

//--- lit_cell.sv
`timescale 1ns/10ps

module lit_cell import sat_bcp_pkg::*; #(
    parameter int WIDTH_LVL = WIDTH_LVL_D
) (
    input  var_t                 var_i,
    input  logic [WIDTH_LVL-1:0] lvl_i,
    input  lit_e                 lit_i,
    input  logic                 imp_drv_i,
    output var_t                 var_o,
    output logic                 is_free_o,
    output logic                 is_sat_o,
    output logic                 is_false_o,
    output logic [WIDTH_LVL-1:0] false_lvl_o
);

    logic lit_pos;
    logic lit_neg;

    assign lit_pos = (lit_i == L_POS);
    assign lit_neg = (lit_i == L_NEG);

    assign is_free_o  = (lit_pos || lit_neg) && (var_i.val == V_FREE);
    assign is_sat_o   = (lit_pos && var_i.val == V_TRUE) || (lit_neg && var_i.val == V_FALSE);
    assign is_false_o = (lit_pos && var_i.val == V_FALSE) || (lit_neg && var_i.val == V_TRUE);

    assign false_lvl_o = is_false_o ? lvl_i : '0;

    // a unit clause writes its only free literal onto the bus
    always_comb begin
        var_o = var_i;
        if (imp_drv_i && is_free_o) begin
            var_o.val = lit_pos ? V_TRUE : V_FALSE;
            var_o.imp = 1'b1;
        end
    end

endmodule

//--- sat_bcp.f
sat_bcp_pkg.sv
lit_cell.sv
lit_array.sv
terminal_cell.sv
clause_cell.sv
var_store.sv
sat_bcp_top.sv
sat_bcp_tb.sv

//--- sat_bcp_pkg.sv
package sat_bcp_pkg;

    // value of one variable as seen on the variable bus
    typedef enum logic [1:0] {
        V_FREE  = 2'd0,
        V_TRUE  = 2'd1,
        V_FALSE = 2'd2
    } val_e;

    // one bus entry; imp marks an implication of this pass, not yet committed
    typedef struct packed {
        val_e val;
        logic imp;
    } var_t;

    // content of one literal slot in a clause
    typedef enum logic [1:0] {
        L_NONE = 2'd0,
        L_POS  = 2'd1,
        L_NEG  = 2'd2
    } lit_e;

    localparam int WIDTH_LVL_D   = 16; // decision level width
    localparam int WIDTH_C_LEN_D = 4;  // clause length width
    localparam int NUM_VARS_D    = 8;
    localparam int NUM_CLAUSES_D = 4;

endpackage

//--- sat_bcp_tb.sv
`timescale 1ns/10ps

module sat_bcp_tb
    import sat_bcp_pkg::*;
();

    localparam int NV  = NUM_VARS_D;
    localparam int NC  = NUM_CLAUSES_D;
    localparam int WL  = WIDTH_LVL_D;
    localparam int WCL = WIDTH_C_LEN_D;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_LOAD,
        OP_READ,
        OP_DECIDE,
        OP_IMPL,
        OP_BKT
    } op_e;

    // each row holds an operation with its operands and then the expected DUT outputs
    typedef struct packed {
        logic [3:0]        test;
        op_e               op;
        logic [2:0]        idx;          // clause or variable index
        val_e              val;
        logic [WL-1:0]     arg;          // backtrack target
        logic [2*NV-1:0]   lits;
        logic [WCL-1:0]    len;
        logic [3*NV-1:0]   exp_var;
        logic [WL-1:0]     exp_cur;
        logic              exp_conflict;
        logic [WL-1:0]     exp_bkt;
        logic              exp_all_sat;
        logic [NC*WCL-1:0] exp_lens;
        logic [2*NV-1:0]   exp_clause;
    } row_t;

    logic                       clk;
    logic                       rst;
    logic [NC-1:0]              wr_i;
    logic [NC-1:0]              rd_i;
    lit_e [NV-1:0]              clause_i;
    logic [WCL-1:0]             clause_len_i;
    lit_e [NV-1:0]              clause_o;
    logic [NC-1:0][WCL-1:0]     clause_len_o;
    logic                       decide_i;
    logic [$clog2(NV)-1:0]      dec_var_i;
    val_e                       dec_val_i;
    logic                       apply_impl_i;
    logic                       apply_bkt_i;
    logic [WL-1:0]              bkt_target_i;
    var_t [NV-1:0]              var_o;
    logic [WL-1:0]              cur_lvl_o;
    logic                       conflict_o;
    logic [WL-1:0]              bkt_lvl_o;
    logic                       all_sat_o;

    row_t        rows[$];
    logic [31:0] rng = 32'd92;
    int          checks;
    int          errors;

    // reference model state
    val_e m_val [NV];
    int   m_lvl [NV];
    int   m_cur;
    lit_e m_lit [NC][NV];
    int   m_len [NC];
    logic m_reason [NC];
    int   m_rlvl [NC];

    // result of one propagation pass through the model
    val_e p_val [NV];
    logic p_imp [NV];
    logic p_unit [NC];
    logic p_conflict;
    int   p_bkt;
    logic p_all_sat;

    sat_bcp_top sat_bcp_top_i (
        .clk          (clk),
        .rst          (rst),
        .wr_i         (wr_i),
        .rd_i         (rd_i),
        .clause_i     (clause_i),
        .clause_len_i (clause_len_i),
        .clause_o     (clause_o),
        .clause_len_o (clause_len_o),
        .decide_i     (decide_i),
        .dec_var_i    (dec_var_i),
        .dec_val_i    (dec_val_i),
        .apply_impl_i (apply_impl_i),
        .apply_bkt_i  (apply_bkt_i),
        .bkt_target_i (bkt_target_i),
        .var_o        (var_o),
        .cur_lvl_o    (cur_lvl_o),
        .conflict_o   (conflict_o),
        .bkt_lvl_o    (bkt_lvl_o),
        .all_sat_o    (all_sat_o)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [2*NV-1:0] lit_bits(input int v, input lit_e l);
        logic [2*NV-1:0] b;
        b = '0;
        b[2*v +: 2] = l;
        return b;
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < NV; i++) begin
            m_val[i] = V_FREE;
            m_lvl[i] = 0;
        end
        for (int k = 0; k < NC; k++) begin
            for (int i = 0; i < NV; i++) begin
                m_lit[k][i] = L_NONE;
            end
            m_len[k]    = 0;
            m_reason[k] = 1'b0;
            m_rlvl[k]   = 0;
        end
        m_cur = 0;
    endfunction

    // clauses see the bus in chain order, so earlier implications count as assignments
    function automatic void propagate();
        int   free_cnt;
        int   free_var;
        int   lv;
        int   max_false;
        logic sat;
        logic nonempty;
        for (int i = 0; i < NV; i++) begin
            p_val[i] = m_val[i];
            p_imp[i] = 1'b0;
        end
        p_conflict = 1'b0;
        p_bkt      = 0;
        p_all_sat  = 1'b1;
        for (int k = 0; k < NC; k++) begin
            free_cnt  = 0;
            free_var  = 0;
            max_false = 0;
            sat       = 1'b0;
            nonempty  = 1'b0;
            for (int i = 0; i < NV; i++) begin
                if (m_lit[k][i] != L_NONE) begin
                    nonempty = 1'b1;
                    lv = (m_val[i] == V_FREE) ? m_cur : m_lvl[i]; // implied now, so current level
                    if (p_val[i] == V_FREE) begin
                        free_cnt++;
                        free_var = i;
                    end else if ((m_lit[k][i] == L_POS && p_val[i] == V_TRUE) ||
                                 (m_lit[k][i] == L_NEG && p_val[i] == V_FALSE)) begin
                        sat = 1'b1;
                    end else if (lv > max_false) begin
                        max_false = lv;
                    end
                end
            end
            p_unit[k] = !sat && free_cnt == 1;
            if (p_unit[k]) begin
                p_val[free_var] = (m_lit[k][free_var] == L_POS) ? V_TRUE : V_FALSE;
                p_imp[free_var] = 1'b1;
            end
            if (nonempty && !sat && free_cnt == 0) begin
                p_conflict = 1'b1;
                if (max_false > p_bkt) begin
                    p_bkt = max_false;
                end
            end
            if (nonempty && !sat) begin
                p_all_sat = 1'b0;
            end
        end
    endfunction

    // steps the model through one operation and appends the row with its expected outputs
    function automatic void add_row(input int test, input op_e op, input int idx,
                                    input val_e val, input int arg,
                                    input logic [2*NV-1:0] lits, input int len);
        row_t r;
        r      = '0;
        r.test = 4'(test);
        r.op   = op;
        r.idx  = 3'(idx);
        r.val  = val;
        r.arg  = WL'(arg);
        r.lits = lits;
        r.len  = WCL'(len);
        case (op)
            OP_LOAD: begin
                for (int i = 0; i < NV; i++) begin
                    m_lit[idx][i] = lit_e'(lits[2*i +: 2]);
                end
                m_len[idx]    = len;
                m_reason[idx] = 1'b0;
            end
            OP_DECIDE: begin
                m_cur++;
                m_val[idx] = val;
                m_lvl[idx] = m_cur;
            end
            OP_IMPL: begin
                propagate();
                for (int k = 0; k < NC; k++) begin
                    if (p_unit[k]) begin
                        m_reason[k] = 1'b1;
                        m_rlvl[k]   = m_cur;
                    end
                end
                for (int i = 0; i < NV; i++) begin
                    if (p_imp[i]) begin
                        m_val[i] = p_val[i];
                        m_lvl[i] = m_cur;
                    end
                end
            end
            OP_BKT: begin
                for (int k = 0; k < NC; k++) begin
                    if (m_reason[k] && arg < m_rlvl[k]) begin
                        m_reason[k] = 1'b0;
                    end
                end
                for (int i = 0; i < NV; i++) begin
                    if (m_val[i] != V_FREE && m_lvl[i] > arg) begin
                        m_val[i] = V_FREE;
                    end
                end
                m_cur = arg;
            end
            default: ;
        endcase
        propagate();
        for (int i = 0; i < NV; i++) begin
            r.exp_var[3*i +: 3] = {p_val[i], p_imp[i]};
        end
        for (int k = 0; k < NC; k++) begin
            r.exp_lens[WCL*k +: WCL] = m_reason[k] ? '0 : WCL'(m_len[k]);
        end
        if (op == OP_READ) begin
            for (int i = 0; i < NV; i++) begin
                r.exp_clause[2*i +: 2] = m_lit[idx][i];
            end
        end
        r.exp_cur      = WL'(m_cur);
        r.exp_conflict = p_conflict;
        r.exp_bkt      = WL'(p_bkt);
        r.exp_all_sat  = p_all_sat;
        rows.push_back(r);
    endfunction

    // random decisions over the loaded clauses, with implication and backtrack as needed
    function automatic void add_random_rows(input int count);
        int   v;
        int   pick;
        logic found;
        logic any_imp;
        for (int n = 0; n < count; n++) begin
            propagate();
            any_imp = 1'b0;
            for (int i = 0; i < NV; i++) begin
                any_imp = any_imp | p_imp[i];
            end
            rng = xorshift32(rng);
            if (p_conflict) begin
                add_row(6, OP_BKT, 0, V_FREE, (m_cur == 0) ? 0 : int'(rng % m_cur), '0, 0);
            end else if (any_imp) begin
                add_row(6, OP_IMPL, 0, V_FREE, 0, '0, 0);
            end else begin
                found = 1'b0;
                pick  = 0;
                v     = int'(rng % NV);
                for (int j = 0; j < NV; j++) begin
                    if (!found && m_val[(v + j) % NV] == V_FREE) begin
                        found = 1'b1;
                        pick  = (v + j) % NV;
                    end
                end
                if (found) begin
                    add_row(6, OP_DECIDE, pick, rng[8] ? V_TRUE : V_FALSE, 0, '0, 0);
                end else begin
                    add_row(6, OP_BKT, 0, V_FREE, 0, '0, 0);
                end
            end
        end
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1: return "reset, load and read";
            2: return "single implication and commit";
            3: return "chained implication";
            4: return "conflict and backtrack level";
            5: return "backtrack";
            default: return "random decisions";
        endcase
    endfunction

    task automatic check_value(input int row, input string name,
                               input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: row %0d %s got %h expected %h", row, name, got, exp);
        end
    endtask

    task automatic report_test(input int t, input int err_start);
        if (errors == err_start) begin
            $display("test %0d (%s) passed", t, test_name(t));
        end else begin
            $display("test %0d (%s) failed with %0d mismatches", t, test_name(t),
                     errors - err_start);
        end
    endtask

    task automatic drive_idle();
        wr_i = '0;
        rd_i = '0;
        for (int i = 0; i < NV; i++) begin
            clause_i[i] = L_NONE;
        end
        clause_len_i = '0;
        decide_i     = 1'b0;
        dec_var_i    = '0;
        dec_val_i    = V_FREE;
        apply_impl_i = 1'b0;
        apply_bkt_i  = 1'b0;
        bkt_target_i = '0;
    endtask

    task automatic drive_row(input row_t r);
        drive_idle();
        for (int i = 0; i < NV; i++) begin
            clause_i[i] = lit_e'(r.lits[2*i +: 2]);
        end
        clause_len_i = r.len;
        wr_i         = (r.op == OP_LOAD) ? NC'(1) << r.idx : '0;
        rd_i         = (r.op == OP_READ) ? NC'(1) << r.idx : '0;
        decide_i     = (r.op == OP_DECIDE);
        dec_var_i    = r.idx;
        dec_val_i    = r.val;
        apply_impl_i = (r.op == OP_IMPL);
        apply_bkt_i  = (r.op == OP_BKT);
        bkt_target_i = r.arg;
    endtask

    initial begin
        int   cycles;
        int   cur_test;
        int   err_start;
        row_t r;
        clk    = 1'b0;
        rst    = 1'b0;
        checks = 0;
        errors = 0;
        drive_idle();

        model_reset();
        add_row(1, OP_IDLE, 0, V_FREE, 0, '0, 0);
        add_row(1, OP_LOAD, 0, V_FREE, 0,
                lit_bits(0, L_NEG) | lit_bits(1, L_NEG) | lit_bits(2, L_POS), 3);
        add_row(1, OP_LOAD, 1, V_FREE, 0, lit_bits(2, L_NEG) | lit_bits(3, L_POS), 2);
        add_row(1, OP_LOAD, 2, V_FREE, 0, lit_bits(4, L_NEG) | lit_bits(5, L_NEG), 2);
        add_row(1, OP_LOAD, 3, V_FREE, 0,
                lit_bits(6, L_POS) | lit_bits(7, L_POS) | lit_bits(4, L_NEG), 3);
        for (int k = 0; k < NC; k++) begin
            add_row(1, OP_READ, k, V_FREE, 0, '0, 0);
        end
        add_row(1, OP_IDLE, 0, V_FREE, 0, '0, 0);
        add_row(2, OP_DECIDE, 4, V_TRUE, 0, '0, 0);   // clause 2 implies x5 false
        add_row(2, OP_IMPL, 0, V_FREE, 0, '0, 0);
        add_row(3, OP_DECIDE, 0, V_TRUE, 0, '0, 0);
        add_row(3, OP_DECIDE, 1, V_TRUE, 0, '0, 0);   // x2 then x3 in one pass
        add_row(3, OP_IMPL, 0, V_FREE, 0, '0, 0);
        add_row(4, OP_DECIDE, 6, V_FALSE, 0, '0, 0);
        add_row(4, OP_DECIDE, 7, V_FALSE, 0, '0, 0);  // clause 3 all false
        add_row(5, OP_BKT, 0, V_FREE, 2, '0, 0);
        add_row(5, OP_BKT, 0, V_FREE, 0, '0, 0);
        add_row(5, OP_DECIDE, 4, V_TRUE, 0, '0, 0);
        add_row(5, OP_DECIDE, 6, V_FALSE, 0, '0, 0);
        add_row(5, OP_DECIDE, 7, V_FALSE, 0, '0, 0);  // clause 3 false up to level 3
        add_row(5, OP_DECIDE, 5, V_TRUE, 0, '0, 0);   // clause 2 also false, at level 4
        add_row(5, OP_BKT, 0, V_FREE, 1, '0, 0);
        add_random_rows(24);

        for (int n = 0; n < 10; n++) begin
            @(posedge clk);
        end
        #1 rst = 1'b1;

        cycles = 0;
        while (all_sat_o !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (all_sat_o !== 1'b1) begin
            errors++;
            $display("DUT stalled: all_sat_o did not rise within 20 cycles after reset");
        end

        cur_test  = rows[0].test;
        err_start = errors;
        for (int n = 0; n < rows.size(); n++) begin
            r = rows[n];
            if (r.test != cur_test) begin
                report_test(cur_test, err_start);
                cur_test  = r.test;
                err_start = errors;
            end
            @(posedge clk);
            #1 drive_row(r);
            @(negedge clk);
            check_value(n, "clause_o", clause_o, r.exp_clause);
            @(posedge clk);
            #1 drive_idle();
            @(negedge clk);    // results of the strobe show in this cycle
            check_value(n, "var_o", var_o, r.exp_var);
            check_value(n, "cur_lvl_o", cur_lvl_o, r.exp_cur);
            check_value(n, "conflict_o", conflict_o, r.exp_conflict);
            check_value(n, "bkt_lvl_o", bkt_lvl_o, r.exp_bkt);
            check_value(n, "all_sat_o", all_sat_o, r.exp_all_sat);
            check_value(n, "clause_len_o", clause_len_o, r.exp_lens);
            check_value(n, "clause_o", clause_o, '0);
        end
        report_test(cur_test, err_start);

        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sat_bcp_top.sv
`timescale 1ns/10ps

module sat_bcp_top import sat_bcp_pkg::*; #(
    parameter int NUM_VARS    = NUM_VARS_D,
    parameter int NUM_CLAUSES = NUM_CLAUSES_D,
    parameter int WIDTH_LVL   = WIDTH_LVL_D,
    parameter int WIDTH_C_LEN = WIDTH_C_LEN_D
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [NUM_CLAUSES-1:0]                 wr_i,
    input  logic [NUM_CLAUSES-1:0]                 rd_i,
    input  lit_e [NUM_VARS-1:0]                    clause_i,
    input  logic [WIDTH_C_LEN-1:0]                 clause_len_i,
    output lit_e [NUM_VARS-1:0]                    clause_o,
    output logic [NUM_CLAUSES-1:0][WIDTH_C_LEN-1:0] clause_len_o,
    input  logic                                   decide_i,
    input  logic [$clog2(NUM_VARS)-1:0]            dec_var_i,
    input  val_e                                   dec_val_i,
    input  logic                                   apply_impl_i,
    input  logic                                   apply_bkt_i,
    input  logic [WIDTH_LVL-1:0]                   bkt_target_i,
    output var_t [NUM_VARS-1:0]                    var_o,
    output logic [WIDTH_LVL-1:0]                   cur_lvl_o,
    output logic                                   conflict_o,
    output logic [WIDTH_LVL-1:0]                   bkt_lvl_o,
    output logic                                   all_sat_o
);

    var_t [NUM_CLAUSES:0][NUM_VARS-1:0]     var_chain;
    logic [NUM_CLAUSES:0][WIDTH_LVL-1:0]    lvl_chain;
    logic [NUM_VARS-1:0][WIDTH_LVL-1:0]     lvl_bus;
    logic [WIDTH_LVL-1:0]                   cur_lvl;
    lit_e [NUM_CLAUSES-1:0][NUM_VARS-1:0]   clause_rd;
    logic [NUM_CLAUSES-1:0]                 cclause;
    logic [NUM_CLAUSES-1:0]                 sat;
    logic [2*NUM_VARS-1:0]                  clause_bits;

    var_store #(
        .NUM_VARS  (NUM_VARS),
        .WIDTH_LVL (WIDTH_LVL)
    ) var_store_i (
        .clk          (clk),
        .rst          (rst),
        .var_i        (var_chain[NUM_CLAUSES]),
        .var_o        (var_chain[0]),
        .lvl_o        (lvl_bus),
        .cur_lvl_o    (cur_lvl),
        .decide_i     (decide_i),
        .dec_var_i    (dec_var_i),
        .dec_val_i    (dec_val_i),
        .apply_impl_i (apply_impl_i),
        .apply_bkt_i  (apply_bkt_i),
        .bkt_target_i (bkt_target_i)
    );

    assign lvl_chain[0] = '0;

    for (genvar k = 0; k < NUM_CLAUSES; k++) begin : g_clause
        clause_cell #(
            .NUM_VARS    (NUM_VARS),
            .WIDTH_LVL   (WIDTH_LVL),
            .WIDTH_C_LEN (WIDTH_C_LEN)
        ) clause_cell_i (
            .clk          (clk),
            .rst          (rst),
            .var_i        (var_chain[k]),
            .var_o        (var_chain[k+1]),
            .lvl_i        (lvl_bus),
            .cur_lvl_i    (cur_lvl),
            .chain_lvl_i  (lvl_chain[k]),
            .chain_lvl_o  (lvl_chain[k+1]),
            .wr_i         (wr_i[k]),
            .rd_i         (rd_i[k]),
            .clause_i     (clause_i),
            .clause_o     (clause_rd[k]),
            .clause_len_i (clause_len_i),
            .clause_len_o (clause_len_o[k]),
            .apply_impl_i (apply_impl_i),
            .apply_bkt_i  (apply_bkt_i),
            .bkt_target_i (bkt_target_i),
            .cclause_o    (cclause[k]),
            .sat_o        (sat[k])
        );
    end

    // unselected cells return zero, so the read bus is a plain OR
    always_comb begin
        clause_bits = '0;
        for (int k = 0; k < NUM_CLAUSES; k++) begin
            clause_bits = clause_bits | clause_rd[k];
        end
        for (int i = 0; i < NUM_VARS; i++) begin
            clause_o[i] = lit_e'(clause_bits[2*i +: 2]);
        end
    end

    assign var_o      = var_chain[NUM_CLAUSES];
    assign cur_lvl_o  = cur_lvl;
    assign bkt_lvl_o  = lvl_chain[NUM_CLAUSES];
    assign conflict_o = |cclause;
    assign all_sat_o  = &sat;

endmodule

//--- terminal_cell.sv
`timescale 1ns/10ps

module terminal_cell import sat_bcp_pkg::*; #(
    parameter int WIDTH_LVL = WIDTH_LVL_D
) (
    input  logic                 clausesat_i,
    input  logic [1:0]           freelitcnt_i,
    input  logic                 nonempty_i,
    input  logic [WIDTH_LVL-1:0] max_lvl_i,
    input  logic [WIDTH_LVL-1:0] chain_lvl_i,
    output logic                 imp_drv_o,
    output logic                 cclause_o,
    output logic [WIDTH_LVL-1:0] chain_lvl_o
);

    logic unit;
    logic conflict;

    // one free literal left and nothing satisfied yet
    assign unit = !clausesat_i && (freelitcnt_i == 2'd1);

    // every literal is false
    assign conflict = nonempty_i && !clausesat_i && (freelitcnt_i == 2'd0);

    assign imp_drv_o = unit;
    assign cclause_o = conflict;

    // backtrack level is the highest false level over all conflicting clauses
    always_comb begin
        chain_lvl_o = chain_lvl_i;
        if (conflict && max_lvl_i > chain_lvl_i) begin
            chain_lvl_o = max_lvl_i;
        end
    end

endmodule

//--- var_store.sv
`timescale 1ns/10ps

module var_store import sat_bcp_pkg::*; #(
    parameter int NUM_VARS  = NUM_VARS_D,
    parameter int WIDTH_LVL = WIDTH_LVL_D
) (
    input  logic                                clk,
    input  logic                                rst,
    input  var_t [NUM_VARS-1:0]                 var_i,
    output var_t [NUM_VARS-1:0]                 var_o,
    output logic [NUM_VARS-1:0][WIDTH_LVL-1:0] lvl_o,
    output logic [WIDTH_LVL-1:0]                cur_lvl_o,
    input  logic                                decide_i,
    input  logic [$clog2(NUM_VARS)-1:0]         dec_var_i,
    input  val_e                                dec_val_i,
    input  logic                                apply_impl_i,
    input  logic                                apply_bkt_i,
    input  logic [WIDTH_LVL-1:0]                bkt_target_i
);

    val_e [NUM_VARS-1:0]                 val_r;
    logic [NUM_VARS-1:0][WIDTH_LVL-1:0] lvl_r;
    logic [WIDTH_LVL-1:0]                cur_lvl;

    // backtrack over decide over implication
    always_ff @(posedge clk) begin
        if (!rst) begin
            cur_lvl <= '0;
            for (int i = 0; i < NUM_VARS; i++) begin
                val_r[i] <= V_FREE;
            end
        end else if (apply_bkt_i) begin
            cur_lvl <= bkt_target_i;
            for (int i = 0; i < NUM_VARS; i++) begin
                if (val_r[i] != V_FREE && lvl_r[i] > bkt_target_i) begin
                    val_r[i] <= V_FREE;
                end
            end
        end else if (decide_i) begin
            cur_lvl          <= cur_lvl + 1'b1;
            val_r[dec_var_i] <= dec_val_i;
        end else if (apply_impl_i) begin
            for (int i = 0; i < NUM_VARS; i++) begin
                if (var_i[i].imp) begin
                    val_r[i] <= var_i[i].val;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!apply_bkt_i) begin
            if (decide_i) begin
                lvl_r[dec_var_i] <= cur_lvl + 1'b1; // new decision level
            end else if (apply_impl_i) begin
                for (int i = 0; i < NUM_VARS; i++) begin
                    if (var_i[i].imp) begin
                        lvl_r[i] <= cur_lvl;
                    end
                end
            end
        end
    end

    // a free variable can only be implied in this pass, so it reports the current level
    always_comb begin
        for (int i = 0; i < NUM_VARS; i++) begin
            var_o[i].val = val_r[i];
            var_o[i].imp = 1'b0;
            lvl_o[i]     = (val_r[i] == V_FREE) ? cur_lvl : lvl_r[i];
        end
    end

    assign cur_lvl_o = cur_lvl;

endmodule
